// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = idec_tb
FLIST = tb.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: source/ctrl_buffer.sv
// one-stage buffer for the control word and operand
`default_nettype none

module ctrl_buffer
    import idec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  buf_ctrl_t in,
    output buf_ctrl_t out
);

    logic       valid_q;
    ctrl_t      ctrl_q;
    logic [7:0] operand_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in.valid;
        end
    end

    // an idle slot carries no strobes.
    always_ff @(posedge clk) begin
        if (reset || !in.valid) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= in.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        operand_q <= in.operand;
    end

    assign out = '{valid: valid_q, ctrl: ctrl_q, operand: operand_q};

endmodule

`default_nettype wire

// File: source/group_decoder.sv
// combinational decoder for opcode group 00001xx1
`default_nettype none

module group_decoder
    import idec_pkg::*;
(
    input  logic    enable,
    input  opcode_u opcode,
    input  xpt_t    xpt,
    output ctrl_t   ctrl
);

    logic in_group;
    logic ph0;
    logic ph1;
    logic ph2;

    logic d_00001x01;
    logic d_00001x11;
    logic d_00001101;
    logic d_00001011;
    logic d_00001111;

    logic end_x01;
    logic end_x11;
    logic end_nop;
    logic inv_x01;
    logic inv_x11;

    // group field and low bit are shared by all four opcodes.
    assign in_group = enable
                   && (opcode.f.group == op_ld_pair[7:3])
                   && (opcode.f.low == op_ld_pair[0]);

    assign ph0 = (xpt == xpt_t'(0));
    assign ph1 = (xpt == xpt_t'(1));
    assign ph2 = (xpt == xpt_t'(2));

    // first split on opcode bit 1.
    assign d_00001x01 = in_group && (opcode.f.sel[0] == op_ld_pair[1]);
    assign d_00001x11 = in_group && (opcode.f.sel[0] == op_ld_ix_h[1]);

    // then on opcode bit 2.
    assign d_00001101 = d_00001x01 && (opcode.f.sel[1] == op_ld_pair_inv[2]);
    assign d_00001011 = d_00001x11 && (opcode.f.sel[1] == op_ld_ix_h[2]);
    assign d_00001111 = d_00001x11 && (opcode.f.sel[1] == op_ld_iy_inv[2]);

    // pair loads take three phases of low, high and end.
    assign inv_x01 = d_00001101 && ph0;
    assign end_x01 = d_00001x01 && ph2;

    // index-high loads take two phases of write and end.
    assign inv_x11 = d_00001111 && ph0;
    assign end_x11 = d_00001x11 && ph1;

    assign end_nop = enable && !in_group; // anything else is a one-phase no-op.

    assign ctrl.write_l       = d_00001x01 && ph0;
    assign ctrl.write_h       = d_00001x01 && ph1;
    assign ctrl.write_ix_high = d_00001011 && ph0;
    assign ctrl.write_iy_high = d_00001111 && ph0;
    assign ctrl.invert_in     = inv_x01 || inv_x11;
    assign ctrl.reset_xpt     = end_x01 || end_x11 || end_nop;

endmodule

`default_nettype wire

// File: source/idec_pkg.sv
// opcode union, phase type, control-word structs and opcode constants for the decode slice
`default_nettype none

package idec_pkg;

    // opcode byte split into group, selector and low bit.
    typedef struct packed {
        logic [4:0] group;
        logic [1:0] sel;
        logic       low;
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t f;
    } opcode_u;

    typedef logic [3:0] xpt_t; // execution phase.

    typedef struct packed {
        logic write_l;
        logic write_h;
        logic invert_in;
        logic write_ix_high;
        logic write_iy_high;
        logic reset_xpt; // last phase of the instruction.
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        logic [7:0] operand;
    } buf_ctrl_t;

    // group 00001xx1.
    localparam logic [7:0] op_ld_pair     = 8'h09;
    localparam logic [7:0] op_ld_ix_h     = 8'h0b;
    localparam logic [7:0] op_ld_pair_inv = 8'h0d;
    localparam logic [7:0] op_ld_iy_inv   = 8'h0f;

endpackage

`default_nettype wire

// File: source/idec_top.sv
// top level of the decode slice: sequencer, group decoder, control buffer, register unit
`default_nettype none

module idec_top
    import idec_pkg::*;
#(
    parameter int xpt_max = 15
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        op_valid,
    input  opcode_u     opcode,
    input  logic [7:0]  operand,
    output logic        busy,
    output logic        done,
    output logic [15:0] pair,
    output logic [7:0]  ix_high,
    output logic [7:0]  iy_high
);

    logic       enable;
    opcode_u    opcode_q;
    logic [7:0] operand_q;
    xpt_t       xpt;
    ctrl_t      ctrl;
    buf_ctrl_t  buf_in;
    buf_ctrl_t  buf_out;

    phase_sequencer #(
        .xpt_max(xpt_max)
    ) phase_sequencer_i (
        .clk      (clk),
        .reset    (reset),
        .op_valid (op_valid),
        .opcode   (opcode),
        .operand  (operand),
        .reset_xpt(ctrl.reset_xpt),
        .enable   (enable),
        .busy     (busy),
        .opcode_q (opcode_q),
        .operand_q(operand_q),
        .xpt      (xpt)
    );

    group_decoder group_decoder_i (
        .enable(enable),
        .opcode(opcode_q),
        .xpt   (xpt),
        .ctrl  (ctrl)
    );

    assign buf_in = '{valid: enable, ctrl: ctrl, operand: operand_q};

    ctrl_buffer ctrl_buffer_i (
        .clk  (clk),
        .reset(reset),
        .in   (buf_in),
        .out  (buf_out)
    );

    reg_unit reg_unit_i (
        .clk    (clk),
        .reset  (reset),
        .in     (buf_out),
        .done   (done),
        .pair   (pair),
        .ix_high(ix_high),
        .iy_high(iy_high)
    );

endmodule

`default_nettype wire

// File: source/phase_sequencer.sv
// phase sequencer: opcode and operand latch plus execution-phase counter
`default_nettype none

module phase_sequencer
    import idec_pkg::*;
#(
    parameter int xpt_max = 15
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       op_valid,
    input  opcode_u    opcode,
    input  logic [7:0] operand,
    input  logic       reset_xpt,
    output logic       enable,
    output logic       busy,
    output opcode_u    opcode_q,
    output logic [7:0] operand_q,
    output xpt_t       xpt
);

    logic start;
    logic last_phase;

    assign start = op_valid && !enable; // requests while busy are dropped.

    // end on the decoder's request, or force it at the phase limit.
    assign last_phase = reset_xpt || (xpt == xpt_t'(xpt_max));

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
            xpt    <= '0;
        end else if (start) begin
            enable <= 1'b1;
            xpt    <= '0;
        end else if (enable) begin
            if (last_phase) begin
                enable <= 1'b0;
                xpt    <= '0;
            end else begin
                xpt <= xpt + xpt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            opcode_q  <= opcode;
            operand_q <= operand;
        end
    end

    assign busy = enable; // high for exactly one cycle per phase.

endmodule

`default_nettype wire

// File: source/reg_unit.sv
// register unit: register pair, index-high bytes and done pulse
`default_nettype none

module reg_unit
    import idec_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  buf_ctrl_t   in,
    output logic        done,
    output logic [15:0] pair,
    output logic [7:0]  ix_high,
    output logic [7:0]  iy_high
);

    logic [7:0] wdata;
    logic       wr_l;
    logic       wr_h;
    logic       wr_ix;
    logic       wr_iy;

    assign wdata = in.ctrl.invert_in ? ~in.operand : in.operand;

    assign wr_l  = in.valid && in.ctrl.write_l;
    assign wr_h  = in.valid && in.ctrl.write_h;
    assign wr_ix = in.valid && in.ctrl.write_ix_high;
    assign wr_iy = in.valid && in.ctrl.write_iy_high;

    always_ff @(posedge clk) begin
        if (reset) begin
            pair <= '0;
        end else begin
            if (wr_l) begin
                pair[7:0] <= wdata;
            end
            if (wr_h) begin
                pair[15:8] <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ix_high <= '0;
            iy_high <= '0;
        end else begin
            if (wr_ix) begin
                ix_high <= wdata;
            end
            if (wr_iy) begin
                iy_high <= wdata;
            end
        end
    end

    // last phase reached the registers, so the instruction is complete.
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= in.valid && in.ctrl.reset_xpt;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
source/idec_pkg.sv
source/phase_sequencer.sv
source/group_decoder.sv
source/ctrl_buffer.sv
source/reg_unit.sv
source/idec_top.sv
test/idec_asserts.sv
test/idec_tb.sv

// File: test/idec_asserts.sv
// concurrent assertions on idec_top and the bind that attaches them
`default_nettype none

module idec_asserts
    import idec_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      busy,
    input logic      done,
    input buf_ctrl_t buf_out
);

    int done_fails   = 0;
    int reset_fails  = 0;
    int onehot_fails = 0;
    int failures;

    assign failures = done_fails + reset_fails + onehot_fails;

    // done is a single-cycle pulse.
    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            done_fails++;
            $error("done high two cycles running");
        end

    reset_idle: assert property (@(posedge clk) reset |=> !busy && !done)
        else begin
            reset_fails++;
            $error("busy or done high after reset");
        end

    // only one byte register is written per phase.
    one_write: assert property (@(posedge clk) disable iff (reset)
        $onehot0({buf_out.ctrl.write_l, buf_out.ctrl.write_h,
                  buf_out.ctrl.write_ix_high, buf_out.ctrl.write_iy_high}))
        else begin
            onehot_fails++;
            $error("more than one write strobe in the buffered word");
        end

endmodule

bind idec_top idec_asserts idec_asserts_i (
    .clk    (clk),
    .reset  (reset),
    .busy   (busy),
    .done   (done),
    .buf_out(buf_out)
);

`default_nettype wire

// File: test/idec_stim.txt
# columns: opcode operand pair ix_high iy_high n, all hex
# expected values are the register state once the instruction's done arrives
09 12 1212 00 00 3  # op_ld_pair
0d 34 34cb 00 00 3  # op_ld_pair_inv
0b 56 34cb 56 00 2  # op_ld_ix_h
0f 78 34cb 56 87 2  # op_ld_iy_inv
00 ff 34cb 56 87 1
08 11 34cb 56 87 1
01 22 34cb 56 87 1
19 33 34cb 56 87 1
89 44 34cb 56 87 1
0a 55 34cb 56 87 1
0e 66 34cb 56 87 1
09 00 0000 56 87 3
0d 00 00ff 56 87 3
0b ff 00ff ff 87 2
0f ff 00ff ff 00 2
09 ff ffff ff 00 3
0d ff ff00 ff 00 3
0b 00 ff00 00 00 2
0f 00 ff00 00 ff 2
49 a5 ff00 00 ff 1
09 a5 a5a5 00 ff 3
0d 5a 5aa5 00 ff 3
0b c3 5aa5 c3 ff 2
0f 3c 5aa5 c3 c3 2
0f 3c 5aa5 c3 c3 2
0b 3c 5aa5 3c c3 2
0d c3 c33c 3c c3 3
09 81 8181 3c c3 3
ff 00 8181 3c c3 1
0c 99 8181 3c c3 1
0f 01 8181 3c fe 2
0d 7e 7e81 3c fe 3
09 e7 e7e7 3c fe 3
0b 10 e7e7 10 fe 2
cb 20 e7e7 10 fe 1

// File: test/idec_tb.sv
// testbench for idec_top: stimulus file reader, driver, done monitor, compare tasks and watchdog
`default_nettype none

module idec_tb
    import idec_pkg::*;
;

    typedef struct packed {
        opcode_u     opcode;
        logic [7:0]  operand;
        logic [15:0] pair;
        logic [7:0]  ix_high;
        logic [7:0]  iy_high;
        logic [3:0]  n; // phases of the instruction.
    } stim_t;

    typedef struct packed {
        stim_t s;
        int    issue_cycle;
    } expect_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        op_valid;
    opcode_u     opcode;
    logic [7:0]  operand;
    logic        busy;
    logic        done;
    logic [15:0] pair;
    logic [7:0]  ix_high;
    logic [7:0]  iy_high;

    stim_t   stim[$];
    expect_t pending[$]; // issued, done not seen yet.
    expect_t done_exp;
    int      cycle = 0;
    int      seed;
    int      gap;
    logic    poke;
    bit      stim_loaded = 1'b0;
    int      value_errs = 0;
    int      other_errs = 0;
    int      assert_errs;
    int      limit;

    idec_top #(
        .xpt_max(15)
    ) idec_top_i (
        .clk     (clk),
        .reset   (reset),
        .op_valid(op_valid),
        .opcode  (opcode),
        .operand (operand),
        .busy    (busy),
        .done    (done),
        .pair    (pair),
        .ix_high (ix_high),
        .iy_high (iy_high)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_pair(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errs++;
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errs++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          r;
        string       line;
        logic [7:0]  op;
        logic [7:0]  opnd;
        logic [15:0] p;
        logic [7:0]  ix;
        logic [7:0]  iy;
        logic [3:0]  n;
        stim_t       s;
        fd = $fopen("test/idec_stim.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("cannot open test/idec_stim.txt, no instructions were run");
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r > 0 && line.len() > 0 && line[0] != "#") begin
                    r = $sscanf(line, "%h %h %h %h %h %h", op, opnd, p, ix, iy, n);
                    if (r == 6) begin
                        s.opcode.raw = op;
                        s.operand    = opnd;
                        s.pair       = p;
                        s.ix_high    = ix;
                        s.iy_high    = iy;
                        s.n          = n;
                        stim.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // starts at posedge+1 and returns at posedge+1 of the first idle cycle.
    task automatic issue_instr(input stim_t s, input logic extra);
        int      busy_cycles;
        expect_t e;
        busy_cycles   = 0;
        op_valid      = 1'b1;
        opcode        = s.opcode;
        operand       = s.operand;
        e.s           = s;
        e.issue_cycle = cycle;
        pending.push_back(e);
        @(posedge clk);
        #1;
        op_valid = 1'b0;
        if (extra) begin
            op_valid    = 1'b1; // must be dropped, the sequencer is busy.
            opcode.raw  = op_ld_pair_inv;
            operand     = ~s.operand;
        end
        while (busy) begin
            busy_cycles++;
            @(posedge clk);
            #1;
            op_valid = 1'b0;
        end
        check_count("busy cycles", int'(s.n), busy_cycles);
    endtask

    // done completes the oldest outstanding instruction.
    always @(negedge clk) begin
        if (!reset && done) begin
            if (pending.size() == 0) begin
                other_errs++;
                $display("done pulsed at %0t with no instruction outstanding", $time);
            end else begin
                done_exp = pending.pop_front();
                check_count("done latency", int'(done_exp.s.n) + 2,
                            cycle - done_exp.issue_cycle);
                check_pair("pair", done_exp.s.pair, pair);
                check_byte("ix_high", done_exp.s.ix_high, ix_high);
                check_byte("iy_high", done_exp.s.iy_high, iy_high);
            end
        end
    end

    initial begin : watchdog
        wait (stim_loaded);
        limit = stim.size() * 8 + 50;
        repeat (limit) @(posedge clk);
        $display("timed out: the run did not finish within %0d cycles", limit);
        $display("tests failed");
        $finish;
    end

    initial begin : main
        seed     = 32'hf0ba_0650;
        reset    = 1'b1;
        op_valid = 1'b0;
        opcode   = '0;
        operand  = '0;
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        check_pair("pair", 16'h0000, pair);
        check_byte("ix_high", 8'h00, ix_high);
        check_byte("iy_high", 8'h00, iy_high);
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        foreach (stim[i]) begin
            gap  = $random(seed) & 3; // gap 0 is back to back.
            poke = ($random(seed) & 1) != 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            issue_instr(stim[i], poke);
        end
        while (pending.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // room for a stray done.
        assert_errs = idec_top_i.idec_asserts_i.failures;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errs, other_errs, assert_errs);
        if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
